// ==== Makefile ====
# Verilator build and run of the memory system testbench

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_mem_system \
		-Mdir obj_dir -o tb_mem_system
	./obj_dir/tb_mem_system | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== cache_array.sv ====
// Direct-mapped cache storage
// Tag, valid, dirty and data arrays for 32 lines of four words
// Combinational lookup of the addressed line, updates on the clock edge
`default_nettype none

`include "mem_sys_macros.svh"

module cache_array (
   input  wire                          clk,
   input  wire                          rst,
   input  wire mem_sys_pkg::cache_op_t  op,
   input  wire [`MS_INDEX_W-1:0]        index,
   input  wire [`MS_TAG_W-1:0]          tag,
   input  wire [`MS_OFFSET_W-1:0]       offset,
   input  wire [`MS_DATA_W-1:0]         wdata,
   output logic                         hit,
   output logic                         valid,
   output logic                         dirty,
   output logic [`MS_TAG_W-1:0]         tag_out,
   output logic [`MS_DATA_W-1:0]        word_out
);

   localparam int LINES = 1 << `MS_INDEX_W;
   localparam int WORDS = LINES * `MS_WORDS_PER_LINE;

   // Per-line state bits
   logic [LINES-1:0]        valid_bits;
   logic [LINES-1:0]        dirty_bits;

   // Tags and data words
   logic [`MS_TAG_W-1:0]    tag_mem [0:LINES-1];
   logic [`MS_DATA_W-1:0]   data_mem [0:WORDS-1];

   // Flat word address is line index then word in line
   logic [`MS_INDEX_W+`MS_OFFSET_W-1:0] word_sel;

   logic                    do_write;
   logic                    do_fill;

   assign word_sel = {index, offset};

   // Lookup of the addressed line
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign tag_out  = tag_mem[index];
   assign word_out = data_mem[word_sel];
   assign hit      = valid && (tag_out == tag);

   // Decode the operation
   always_comb begin
      do_write = 1'b0;
      do_fill  = 1'b0;
      case (op)
         mem_sys_pkg::CACHE_WRITE_WORD:  do_write = 1'b1;
         mem_sys_pkg::CACHE_FILL_WORD:   do_fill  = 1'b1;
         // Lookup and victim read leave the line alone
         mem_sys_pkg::CACHE_LOOKUP,
         mem_sys_pkg::CACHE_VICTIM_READ,
         mem_sys_pkg::CACHE_NOP:         ;
         default:                        ;
      endcase
   end

   // Line state
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (do_fill) begin
         // Fresh copy from memory is clean
         valid_bits[index] <= 1'b1;
         dirty_bits[index] <= 1'b0;
      end else if (do_write) begin
         dirty_bits[index] <= 1'b1;
      end
   end

   // Data and tag storage
   always_ff @(posedge clk) begin
      if (do_write || do_fill) begin
         data_mem[word_sel] <= wdata;
      end
      if (do_fill) begin
         tag_mem[index] <= tag;
      end
   end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
// Cache controller FSM
// Accepts one host request, compares tags, writes back a dirty victim,
// fills the line with overlapped bank reads, then finishes with a done pulse
// Illegal requests finish one cycle after acceptance with err
`default_nettype none

`include "mem_sys_macros.svh"

module cache_ctrl (
   input  wire                          clk,
   input  wire                          rst,
   // Host side
   input  wire [`MS_ADDR_W-1:0]         addr,
   input  wire [`MS_DATA_W-1:0]         data_in,
   input  wire                          rd,
   input  wire                          wr,
   output logic [`MS_DATA_W-1:0]        data_out,
   output logic                         done,
   output logic                         stall,
   output logic                         cache_hit,
   output logic                         err,
   // Cache array side
   output mem_sys_pkg::cache_op_t       op,
   output logic [`MS_INDEX_W-1:0]       index,
   output logic [`MS_TAG_W-1:0]         tag,
   output logic [`MS_OFFSET_W-1:0]      offset,
   output logic [`MS_DATA_W-1:0]        wdata,
   input  wire                          hit,
   input  wire                          valid,
   input  wire                          dirty,
   input  wire [`MS_TAG_W-1:0]          tag_out,
   input  wire [`MS_DATA_W-1:0]         word_out,
   // Backing memory side
   output logic [`MS_ADDR_W-1:0]        mem_addr,
   output logic [`MS_DATA_W-1:0]        mem_wdata,
   output logic                         mem_rd,
   output logic                         mem_wr,
   input  wire [`MS_DATA_W-1:0]         mem_rdata,
   input  wire                          mem_stall,
   input  wire                          mem_rd_valid
);

   // Low bit of each address field
   localparam int OFF_LO = 1;
   localparam int IDX_LO = OFF_LO + `MS_OFFSET_W;
   localparam int TAG_LO = IDX_LO + `MS_INDEX_W;

   mem_sys_pkg::ctrl_state_t   state;
   mem_sys_pkg::ctrl_state_t   state_nxt;

   // Latched request
   logic [`MS_ADDR_W-1:0]      req_addr;
   logic [`MS_DATA_W-1:0]      req_data;
   logic                       req_wr;
   logic                       req_err;
   logic [`MS_INDEX_W-1:0]     req_index;
   logic [`MS_TAG_W-1:0]       req_tag;
   logic [`MS_OFFSET_W-1:0]    req_offset;

   // First compare missed
   logic                       miss_seen;

   // Issue count for writeback and fill, top bit marks all fill reads sent
   logic [`MS_OFFSET_W:0]      iss_cnt;
   // Fill words already installed
   logic [`MS_OFFSET_W-1:0]    ret_cnt;

   logic                       accept;
   logic                       illegal;
   logic                       mem_acc;

   assign accept  = (state == mem_sys_pkg::ST_IDLE) && (rd || wr);
   assign illegal = (rd && wr) || addr[0];
   assign mem_acc = (mem_rd || mem_wr) && !mem_stall;

   assign req_offset = req_addr[IDX_LO-1:OFF_LO];
   assign req_index  = req_addr[TAG_LO-1:IDX_LO];
   assign req_tag    = req_addr[`MS_ADDR_W-1:TAG_LO];

   // Host status
   assign done      = (state == mem_sys_pkg::ST_DONE);
   assign stall     = (state != mem_sys_pkg::ST_IDLE);
   assign err       = done && req_err;
   assign cache_hit = done && !req_err && !miss_seen;

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         mem_sys_pkg::ST_IDLE: begin
            if (accept) begin
               state_nxt = illegal ? mem_sys_pkg::ST_DONE : mem_sys_pkg::ST_COMPARE;
            end
         end
         mem_sys_pkg::ST_COMPARE: begin
            if (hit) begin
               state_nxt = mem_sys_pkg::ST_DONE;
            end else if (valid && dirty) begin
               state_nxt = mem_sys_pkg::ST_WRITEBACK;
            end else begin
               state_nxt = mem_sys_pkg::ST_FILL;
            end
         end
         mem_sys_pkg::ST_WRITEBACK: begin
            // Last victim word taken by memory
            if (mem_acc && (iss_cnt == 3)) begin
               state_nxt = mem_sys_pkg::ST_FILL;
            end
         end
         mem_sys_pkg::ST_FILL: begin
            if (mem_rd_valid && (ret_cnt == 2'd3)) begin
               state_nxt = mem_sys_pkg::ST_COMPARE;
            end
         end
         mem_sys_pkg::ST_DONE:    state_nxt = mem_sys_pkg::ST_IDLE;
         default:                 state_nxt = mem_sys_pkg::ST_IDLE;
      endcase
   end

   // Cache array control
   always_comb begin
      op     = mem_sys_pkg::CACHE_NOP;
      index  = req_index;
      tag    = req_tag;
      offset = req_offset;
      wdata  = req_data;
      case (state)
         mem_sys_pkg::ST_COMPARE: begin
            op = (hit && req_wr) ? mem_sys_pkg::CACHE_WRITE_WORD : mem_sys_pkg::CACHE_LOOKUP;
         end
         mem_sys_pkg::ST_WRITEBACK: begin
            op     = mem_sys_pkg::CACHE_VICTIM_READ;
            offset = iss_cnt[`MS_OFFSET_W-1:0];
         end
         mem_sys_pkg::ST_FILL: begin
            // Install returning words in return order
            if (mem_rd_valid) begin
               op     = mem_sys_pkg::CACHE_FILL_WORD;
               offset = ret_cnt;
               wdata  = mem_rdata;
            end
         end
         default: ;
      endcase
   end

   // Memory requests, held steady by the counters while mem_stall is high
   always_comb begin
      mem_addr  = {req_tag, req_index, iss_cnt[`MS_OFFSET_W-1:0], 1'b0};
      mem_wdata = word_out;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      case (state)
         mem_sys_pkg::ST_WRITEBACK: begin
            // Victim goes back under its own tag
            mem_addr = {tag_out, req_index, iss_cnt[`MS_OFFSET_W-1:0], 1'b0};
            mem_wr   = 1'b1;
         end
         mem_sys_pkg::ST_FILL:    mem_rd = !iss_cnt[`MS_OFFSET_W];
         default: ;
      endcase
   end

   // State, flags and counters
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= mem_sys_pkg::ST_IDLE;
         req_wr    <= 1'b0;
         req_err   <= 1'b0;
         miss_seen <= 1'b0;
         iss_cnt   <= '0;
         ret_cnt   <= '0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            req_wr    <= wr;
            req_err   <= illegal;
            miss_seen <= 1'b0;
         end
         if ((state == mem_sys_pkg::ST_COMPARE) && !hit) begin
            miss_seen <= 1'b1;
         end
         // Restart the count at each compare and between writeback and fill
         if (state == mem_sys_pkg::ST_COMPARE) begin
            iss_cnt <= '0;
         end else if (mem_acc) begin
            iss_cnt <= (state_nxt == mem_sys_pkg::ST_FILL && mem_wr) ? '0 : iss_cnt + 1'b1;
         end
         if (mem_rd_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   // Request payload and read result
   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
      end
      if ((state == mem_sys_pkg::ST_COMPARE) && hit) begin
         data_out <= word_out;
      end
   end

endmodule

`default_nettype wire

// ==== four_bank_mem.sv ====
// Four-bank interleaved backing memory
// Word address bits 1:0 pick the bank, so a line spans all four banks
// Per-bank busy countdown drives mem_stall
// Reads return a fixed number of cycles after acceptance, in issue order
`default_nettype none

`include "mem_sys_macros.svh"

module four_bank_mem (
   input  wire                    clk,
   input  wire                    rst,
   input  wire [`MS_ADDR_W-1:0]   mem_addr,
   input  wire [`MS_DATA_W-1:0]   mem_wdata,
   input  wire                    mem_rd,
   input  wire                    mem_wr,
   output logic [`MS_DATA_W-1:0]  mem_rdata,
   output logic                   mem_stall,
   output logic                   mem_rd_valid
);

   localparam int NUM_BANKS  = 4;
   localparam int BANK_WORDS = `MS_MEM_WORDS / NUM_BANKS;
   localparam int ROW_W      = $clog2(BANK_WORDS);
   localparam int BUSY_W     = $clog2(`MS_BANK_BUSY + 1);
   localparam int LAT        = `MS_READ_LATENCY;

   logic [`MS_DATA_W-1:0]   bank_mem [0:NUM_BANKS-1][0:BANK_WORDS-1];

   // Remaining busy cycles of each bank
   logic [BUSY_W-1:0]       busy_cnt [0:NUM_BANKS-1];

   // Read return pipeline
   logic [LAT-1:0]          rd_vld_pipe;
   logic [`MS_DATA_W-1:0]   rd_data_pipe [0:LAT-1];

   logic [`MS_ADDR_W-2:0]   word_addr;
   logic [1:0]              bank;
   logic [ROW_W-1:0]        row;
   logic                    accept;

   // Byte address to word address, bank and row
   assign word_addr = mem_addr[`MS_ADDR_W-1:1];
   assign bank      = word_addr[1:0];
   assign row       = word_addr[ROW_W+1:2];

   assign mem_stall = (busy_cnt[bank] != '0);
   assign accept    = (mem_rd || mem_wr) && !mem_stall;

   assign mem_rdata    = rd_data_pipe[LAT-1];
   assign mem_rd_valid = rd_vld_pipe[LAT-1];

   // Known pattern so the testbench can predict cold reads
   initial begin
      for (int w = 0; w < `MS_MEM_WORDS; w++) begin
         bank_mem[w % NUM_BANKS][w / NUM_BANKS] = 16'(w) ^ 16'h5A5A;
      end
   end

   // Bank busy countdowns
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            if (accept && (bank == 2'(b))) begin
               busy_cnt[b] <= BUSY_W'(`MS_BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Valid bits of the read pipeline
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_vld_pipe <= '0;
      end else begin
         rd_vld_pipe <= {rd_vld_pipe[LAT-2:0], accept && mem_rd};
      end
   end

   // Storage write and read data pipeline
   always_ff @(posedge clk) begin
      if (accept && mem_wr) begin
         bank_mem[bank][row] <= mem_wdata;
      end
      rd_data_pipe[0] <= bank_mem[bank][row];
      for (int s = 1; s < LAT; s++) begin
         rd_data_pipe[s] <= rd_data_pipe[s-1];
      end
   end

endmodule

`default_nettype wire

// ==== mem_sys_macros.svh ====
// Shared width, cache geometry and memory timing macros
// Byte addresses, 16-bit words, four-word lines, 32 direct-mapped lines
`ifndef MEM_SYS_MACROS_SVH
`define MEM_SYS_MACROS_SVH

// Host word and address widths
`define MS_ADDR_W 16
`define MS_DATA_W 16

// Address split is tag [15:8], index [7:3], word [2:1], byte [0]
`define MS_OFFSET_W 2
`define MS_WORDS_PER_LINE 4
`define MS_INDEX_W 5
`define MS_TAG_W 8

// Backing memory size and bank timing
`define MS_MEM_WORDS 32768
`define MS_BANK_BUSY 4
`define MS_READ_LATENCY 2

`endif

// ==== mem_sys_pkg.sv ====
// Memory system types
// Controller FSM states and the cache array operation codes
`default_nettype none

package mem_sys_pkg;

   // Request FSM in the cache controller
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_COMPARE,
      ST_WRITEBACK,
      ST_FILL,
      ST_DONE
   } ctrl_state_t;

   // Operation on the addressed cache line
   typedef enum logic [2:0] {
      CACHE_NOP,
      CACHE_LOOKUP,
      CACHE_WRITE_WORD,
      CACHE_FILL_WORD,
      CACHE_VICTIM_READ
   } cache_op_t;

endpackage

`default_nettype wire

// ==== mem_system.sv ====
// Memory system top level
// Cache controller, direct-mapped cache array and four-bank memory
`default_nettype none

`include "mem_sys_macros.svh"

module mem_system (
   input  wire                    clk,
   input  wire                    rst,
   input  wire [`MS_ADDR_W-1:0]   addr,
   input  wire [`MS_DATA_W-1:0]   data_in,
   input  wire                    rd,
   input  wire                    wr,
   output logic [`MS_DATA_W-1:0]  data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err
);

   // Controller to cache array
   mem_sys_pkg::cache_op_t        arr_op;
   logic [`MS_INDEX_W-1:0]        arr_index;
   logic [`MS_TAG_W-1:0]          arr_tag;
   logic [`MS_OFFSET_W-1:0]       arr_offset;
   logic [`MS_DATA_W-1:0]         arr_wdata;
   logic                          arr_hit;
   logic                          arr_valid;
   logic                          arr_dirty;
   logic [`MS_TAG_W-1:0]          arr_tag_out;
   logic [`MS_DATA_W-1:0]         arr_word;

   // Controller to backing memory
   logic [`MS_ADDR_W-1:0]         mem_addr;
   logic [`MS_DATA_W-1:0]         mem_wdata;
   logic                          mem_rd;
   logic                          mem_wr;
   logic [`MS_DATA_W-1:0]         mem_rdata;
   logic                          mem_stall;
   logic                          mem_rd_valid;

   cache_ctrl ctrl_inst (
      .clk          (clk),
      .rst          (rst),
      .addr         (addr),
      .data_in      (data_in),
      .rd           (rd),
      .wr           (wr),
      .data_out     (data_out),
      .done         (done),
      .stall        (stall),
      .cache_hit    (cache_hit),
      .err          (err),
      .op           (arr_op),
      .index        (arr_index),
      .tag          (arr_tag),
      .offset       (arr_offset),
      .wdata        (arr_wdata),
      .hit          (arr_hit),
      .valid        (arr_valid),
      .dirty        (arr_dirty),
      .tag_out      (arr_tag_out),
      .word_out     (arr_word),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .mem_rdata    (mem_rdata),
      .mem_stall    (mem_stall),
      .mem_rd_valid (mem_rd_valid)
   );

   cache_array array_inst (
      .clk      (clk),
      .rst      (rst),
      .op       (arr_op),
      .index    (arr_index),
      .tag      (arr_tag),
      .offset   (arr_offset),
      .wdata    (arr_wdata),
      .hit      (arr_hit),
      .valid    (arr_valid),
      .dirty    (arr_dirty),
      .tag_out  (arr_tag_out),
      .word_out (arr_word)
   );

   four_bank_mem mem_inst (
      .clk          (clk),
      .rst          (rst),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_rd       (mem_rd),
      .mem_wr       (mem_wr),
      .mem_rdata    (mem_rdata),
      .mem_stall    (mem_stall),
      .mem_rd_valid (mem_rd_valid)
   );

endmodule

`default_nettype wire

// ==== tb_mem_system.sv ====
// Testbench for the cache and banked memory system
// Reference model with a flat word memory and a tag/valid mirror
// Directed cold read, write/read, dirty eviction and illegal request tests
// Random traffic from an xorshift generator with stray requests during stall
`default_nettype none

`include "mem_sys_macros.svh"

module tb_mem_system;

   localparam int WAIT_LIMIT = 200;
   localparam int DONE_LIMIT = 200;
   localparam int LINES      = 1 << `MS_INDEX_W;

   logic                   clk;
   logic                   rst;
   logic [`MS_ADDR_W-1:0]  addr;
   logic [`MS_DATA_W-1:0]  data_in;
   logic                   rd;
   logic                   wr;
   wire  [`MS_DATA_W-1:0]  data_out;
   wire                    done;
   wire                    stall;
   wire                    cache_hit;
   wire                    err;

   // Reference model state
   logic [`MS_DATA_W-1:0]  model_mem [0:`MS_MEM_WORDS-1];
   logic [`MS_TAG_W-1:0]   model_tag [0:LINES-1];
   logic                   model_valid [0:LINES-1];

   // Expected result of each request as {is_read, err, hit, data}
   logic [18:0]            expect_q [$];
   logic [31:0]            rng_state = 32'h56c3cbac;
   int                     errors = 0;
   int                     checks = 0;
   int                     last_latency = 0;

   mem_system mem_system_inst (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Predicts {hit, read data} and updates mirror and memory
   function automatic logic [16:0] predict_access(input logic [15:0] a,
                                                  input logic [15:0] d,
                                                  input logic w);
      logic [`MS_INDEX_W-1:0] idx;
      logic [`MS_TAG_W-1:0]   t;
      logic                   h;
      logic [15:0]            old;
      idx = a[`MS_OFFSET_W+`MS_INDEX_W:`MS_OFFSET_W+1];
      t   = a[`MS_ADDR_W-1:`MS_ADDR_W-`MS_TAG_W];
      h   = model_valid[idx] && (model_tag[idx] == t);
      // Miss allocates the line
      if (!h) begin
         model_valid[idx] = 1'b1;
         model_tag[idx]   = t;
      end
      old = model_mem[a[`MS_ADDR_W-1:1]];
      if (w) begin
         model_mem[a[`MS_ADDR_W-1:1]] = d;
      end
      return {h, old};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic finish_run();
      if (expect_q.size() != 0) begin
         errors++;
         $display("%0d requests never got a done pulse", expect_q.size());
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   endtask

   // One host request; stray holds rd high for a cycle while stalled
   task automatic issue_access(input logic [15:0] a, input logic [15:0] d,
                               input logic r, input logic w, input logic stray);
      int          waited;
      int          cycles;
      logic [16:0] pred;
      logic        bad;
      waited = 0;
      bad    = (r && w) || a[0];
      @(negedge clk);
      while (stall && waited < WAIT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (stall) begin
         errors++;
         $display("Timeout: stall stayed high for %0d cycles", WAIT_LIMIT);
         finish_run();
      end else begin
         @(posedge clk);
         addr    <= a;
         data_in <= d;
         rd      <= r;
         wr      <= w;
         // Accepting edge
         @(posedge clk);
         if (bad) begin
            expect_q.push_back({1'b0, 1'b1, 1'b0, 16'h0000});
         end else begin
            pred = predict_access(a, d, w);
            expect_q.push_back({r, 1'b0, pred});
         end
         rd   <= stray;
         wr   <= 1'b0;
         addr <= a ^ 16'h0100;
         @(negedge clk);
         cycles = 1;
         while (!done && cycles < DONE_LIMIT) begin
            // Busy until the done pulse
            check_value("stall", stall, 1);
            @(posedge clk);
            rd <= 1'b0;
            wr <= 1'b0;
            @(negedge clk);
            cycles++;
         end
         if (!done) begin
            errors++;
            $display("Timeout: no done pulse within %0d cycles", DONE_LIMIT);
            finish_run();
         end else begin
            last_latency = cycles;
         end
      end
   endtask

   // Compare each done pulse with the queued prediction
   always @(negedge clk) begin : compare_done
      logic [18:0] exp_entry;
      if (!rst && done) begin
         if (expect_q.size() == 0) begin
            errors++;
            $display("Done pulse with no request outstanding at %0t", $time);
         end else begin
            exp_entry = expect_q.pop_front();
            check_value("err", err, exp_entry[17]);
            check_value("cache_hit", cache_hit, exp_entry[16]);
            // Read data only for legal reads
            if (exp_entry[18] && !exp_entry[17]) begin
               check_value("data_out", data_out, exp_entry[15:0]);
            end
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      logic [15:0] a;
      int          n;
      rst     = 1'b1;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      for (n = 0; n < `MS_MEM_WORDS; n++) begin
         model_mem[n] = 16'(n) ^ 16'h5A5A;
      end
      for (n = 0; n < LINES; n++) begin
         model_valid[n] = 1'b0;
         model_tag[n]   = '0;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_value("done", done, 0);
      check_value("stall", stall, 0);
      check_value("err", err, 0);
      check_value("cache_hit", cache_hit, 0);

      // Cold miss, then a hit with fixed latency
      issue_access(16'h1234, 16'h0000, 1'b1, 1'b0, 1'b0);
      issue_access(16'h1234, 16'h0000, 1'b1, 1'b0, 1'b0);
      check_value("hit latency", last_latency, 2);

      // Overwrite the whole cached line, read it back
      for (n = 0; n < 4; n++) begin
         issue_access(16'h1230 | 16'(n << 1), 16'hC000 + 16'(n), 1'b0, 1'b1, 1'b0);
      end
      for (n = 0; n < 4; n++) begin
         issue_access(16'h1230 | 16'(n << 1), 16'h0000, 1'b1, 1'b0, 1'b0);
      end

      // Dirty victim at index 2 evicted by another tag
      issue_access(16'h3A10, 16'hBEEF, 1'b0, 1'b1, 1'b0);
      issue_access(16'h5A12, 16'h0000, 1'b1, 1'b0, 1'b0);
      issue_access(16'h3A10, 16'h0000, 1'b1, 1'b0, 1'b0);

      // Illegal requests, then a legal read
      issue_access(16'h3A12, 16'h1111, 1'b1, 1'b1, 1'b0);
      issue_access(16'h3A13, 16'h0000, 1'b1, 1'b0, 1'b0);
      issue_access(16'h0021, 16'h2222, 1'b0, 1'b1, 1'b0);
      issue_access(16'h3A12, 16'h0000, 1'b1, 1'b0, 1'b0);

      // Random traffic over 8 tags and 4 indexes
      for (n = 0; n < 300; n++) begin
         rng_state = xorshift32(rng_state);
         r = rng_state;
         a = {r[2], 5'b00000, r[1:0], 3'b000, r[4:3], r[6:5], 1'b0};
         issue_access(a, r[31:16], !r[7], r[7], r[9:8] == 2'b00);
      end

      repeat (4) @(posedge clk);
      finish_run();
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
mem_sys_pkg.sv
cache_array.sv
four_bank_mem.sv
cache_ctrl.sv
mem_system.sv
tb_mem_system.sv
